//--- a2_card_glue.f
+incdir+rtl
rtl/a2_card_pkg.sv
rtl/bus_clock_sync.sv
rtl/card_bus_arbiter.sv
rtl/card_audio.sv
rtl/status_led.sv
rtl/a2_card_top.sv
tb/tb_a2_card_top.sv

//--- tb/tb_a2_card_top.sv
`timescale 1ns/10ps
`include "a2_card_config.svh"

module tb_a2_card_top
    import a2_card_pkg::*;
();

    localparam int PERIOD = 50;          // Short heartbeat for simulation
    localparam int TIMEOUT_CYCLES = 12000;

    logic          clk_logic_w;
    logic          system_reset_n_w;
    logic          a2_phi1_i;
    logic          a2_q3_i;
    logic          a2_7m_i;
    bus_addr_t     a2_a_i;
    logic          a2_rw_n_i;
    bus_data_t     bus_d_i;
    bus_data_t     ssc_d_i;
    bus_data_t     ssp_d_i;
    bus_data_t     mb_d_i;
    logic          ssc_rd_i;
    logic          ssp_rd_i;
    logic          mb_rd_i;
    logic          ssc_irq_n_i;
    logic          ssp_irq_n_i;
    logic          mb_irq_n_i;
    source_audio_t ssp_audio_i;
    source_audio_t mb_audio_l_i;
    source_audio_t mb_audio_r_i;
    bus_data_t     a2_d_o;
    logic          a2_d_dir_o;
    logic          a2_irq_n_o;
    audio_sample_t audio_l_o;
    audio_sample_t audio_r_o;
    logic          led_o;
    logic          phi1_ind_o;
    logic          q3_ind_o;

    int   value_errors = 0;
    int   other_errors = 0;
    int   bus_phase = 0;
    int   phi1_rises = 0;     // Phi1 rising edges driven after reset release
    logic spk_exp = 1'b0;     // Expected speaker level
    logic audio_check_en = 1'b0;
    logic q3_seen = 1'b0;

    a2_card_top #(
        .LED_PERIOD_CYCLES(PERIOD)
    ) i_a2_card_top (
        .clk_logic_w(clk_logic_w), .system_reset_n_w(system_reset_n_w),
        .a2_phi1_i(a2_phi1_i), .a2_q3_i(a2_q3_i), .a2_7m_i(a2_7m_i),
        .a2_a_i(a2_a_i), .a2_rw_n_i(a2_rw_n_i), .bus_d_i(bus_d_i),
        .ssc_d_i(ssc_d_i), .ssp_d_i(ssp_d_i), .mb_d_i(mb_d_i),
        .ssc_rd_i(ssc_rd_i), .ssp_rd_i(ssp_rd_i), .mb_rd_i(mb_rd_i),
        .ssc_irq_n_i(ssc_irq_n_i), .ssp_irq_n_i(ssp_irq_n_i), .mb_irq_n_i(mb_irq_n_i),
        .ssp_audio_i(ssp_audio_i), .mb_audio_l_i(mb_audio_l_i),
        .mb_audio_r_i(mb_audio_r_i), .a2_d_o(a2_d_o), .a2_d_dir_o(a2_d_dir_o),
        .a2_irq_n_o(a2_irq_n_o), .audio_l_o(audio_l_o), .audio_r_o(audio_r_o),
        .led_o(led_o), .phi1_ind_o(phi1_ind_o), .q3_ind_o(q3_ind_o)
    );

    always #2 clk_logic_w = ~clk_logic_w;

    // Bus clocks, Q3 at twice the Phi1 rate
    always @(posedge clk_logic_w) begin
        #1;
        bus_phase = bus_phase + 1;
        a2_7m_i = ~a2_7m_i;
        if (bus_phase % 2 == 0) begin
            a2_q3_i = ~a2_q3_i;
        end
        if (bus_phase % 4 == 0) begin
            a2_phi1_i = ~a2_phi1_i;
            if (a2_phi1_i && system_reset_n_w) begin
                phi1_rises = phi1_rises + 1;
            end
        end
    end

    function automatic bus_data_t ref_data(input logic ssc_rd, input logic ssp_rd,
                                           input logic mb_rd, input bus_data_t ssc_d,
                                           input bus_data_t ssp_d, input bus_data_t mb_d,
                                           input bus_data_t bus_d);
        if (ssc_rd) begin
            return ssc_d;
        end else if (ssp_rd) begin
            return ssp_d;
        end else if (mb_rd) begin
            return mb_d;
        end
        return bus_d;
    endfunction

    function automatic logic ref_dir(input logic ssc_rd, input logic ssp_rd, input logic mb_rd);
        return (ssc_rd | ssp_rd | mb_rd) & `A2_BUS_DATA_OUT_ENABLE;
    endfunction

    function automatic logic ref_irq(input logic a, input logic b, input logic c);
        if (`A2_IRQ_OUT_ENABLE) begin
            return a & b & c;
        end
        return 1'b1;
    endfunction

    // Card audio sits at bit 3 up, the speaker on bit 12
    function automatic audio_sample_t ref_mix(input source_audio_t src, input source_audio_t card,
                                              input logic spk);
        logic [15:0] sum;
        sum = (16'(src) << `A2_SOURCE_SHIFT) + (16'(card) << `A2_SOURCE_SHIFT)
            + (16'(spk) << `A2_SPEAKER_SHIFT);
        return audio_sample_t'(sum);
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] got);
        value_errors = value_errors + 1;
        $display("Fail %0t ns %s expected %h got %h", $time, name, exp, got);
    endtask

    always @(negedge clk_logic_w) begin : compare
        bus_data_t     exp_d;
        audio_sample_t exp_l;
        audio_sample_t exp_r;
        if (system_reset_n_w) begin
            exp_d = ref_data(ssc_rd_i, ssp_rd_i, mb_rd_i, ssc_d_i, ssp_d_i, mb_d_i, bus_d_i);
            assert (a2_d_o === exp_d) else report_mismatch("a2_d_o", exp_d, a2_d_o);
            assert (a2_d_dir_o === ref_dir(ssc_rd_i, ssp_rd_i, mb_rd_i))
                else report_mismatch("a2_d_dir_o", ref_dir(ssc_rd_i, ssp_rd_i, mb_rd_i),
                                     a2_d_dir_o);
            assert (a2_irq_n_o === ref_irq(ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i))
                else report_mismatch("a2_irq_n_o",
                                     ref_irq(ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i), a2_irq_n_o);
            if (audio_check_en) begin
                exp_l = ref_mix(ssp_audio_i, mb_audio_l_i, spk_exp);
                exp_r = ref_mix(ssp_audio_i, mb_audio_r_i, spk_exp);
                assert (audio_l_o === exp_l) else report_mismatch("audio_l_o", exp_l, audio_l_o);
                assert (audio_r_o === exp_r) else report_mismatch("audio_r_o", exp_r, audio_r_o);
            end
            if (q3_ind_o === 1'b1) begin
                q3_seen = 1'b1;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk_logic_w);
        #1;
    endtask

    // Audio held still long enough to pass the output register
    task automatic hold_and_check_audio();
        repeat (4) next_cycle();
        audio_check_en = 1'b1;
        repeat (6) next_cycle();
        audio_check_en = 1'b0;
    endtask

    // One full Phi1 period at the given address
    task automatic access_address(input bus_addr_t addr, input logic toggles);
        a2_a_i = addr;
        a2_rw_n_i = $urandom_range(0, 1);
        repeat (8) next_cycle();
        a2_a_i = 16'h0400;
        if (toggles) begin
            spk_exp = ~spk_exp;
        end
        hold_and_check_audio();
    endtask

    task automatic check_heartbeat();
        int   waited;
        int   toggles;
        logic last_led;
        ssc_rd_i = 1'b0;
        ssp_rd_i = 1'b0;
        mb_rd_i = 1'b0;
        waited = 0;
        last_led = led_o;
        while (led_o === last_led && waited < 3 * PERIOD + 5) begin
            next_cycle();
            waited = waited + 1;
        end
        if (led_o === last_led) begin
            other_errors = other_errors + 1;
            $display("Timeout at %0t ns: LED never toggled with the bus idle", $time);
        end
        toggles = 0;
        last_led = led_o;
        repeat (4 * PERIOD + PERIOD / 2) begin
            next_cycle();
            if (led_o !== last_led) begin
                toggles = toggles + 1;
            end
            last_led = led_o;
        end
        assert (toggles == 4) else report_mismatch("led_o toggles", 16'd4, 16'(toggles));
        ssc_rd_i = 1'b1;         // Busy bus over two wraps
        repeat (PERIOD) next_cycle();
        assert (led_o === 1'b1) else report_mismatch("led_o", 16'd1, 16'(led_o));
        repeat (PERIOD) next_cycle();   // Second wrap must keep it solid
        assert (led_o === 1'b1) else report_mismatch("led_o", 16'd1, 16'(led_o));
        ssc_rd_i = 1'b0;
    endtask

    task automatic check_indicators();
        int waited;
        waited = 0;
        while (phi1_rises < 1024 && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited = waited + 1;
        end
        if (phi1_rises < 1024) begin
            other_errors = other_errors + 1;
            $display("Timeout at %0t ns: Phi1 did not reach 1024 rising edges", $time);
        end
        repeat (4) next_cycle();   // Sync chain and counter update
        assert (phi1_ind_o === 1'b1) else report_mismatch("phi1_ind_o", 16'd1, 16'(phi1_ind_o));
        assert (q3_seen) else begin
            other_errors = other_errors + 1;
            $display("q3_ind_o never went high before Phi1 reached 1024 edges");
        end
    endtask

    initial begin
        void'($urandom(70307));
        clk_logic_w = 1'b0;
        system_reset_n_w = 1'b0;
        a2_phi1_i = 1'b0;
        a2_q3_i = 1'b0;
        a2_7m_i = 1'b0;
        a2_a_i = 16'h0400;
        a2_rw_n_i = 1'b1;
        bus_d_i = '0;
        ssc_d_i = '0;
        ssp_d_i = '0;
        mb_d_i = '0;
        ssc_rd_i = 1'b0;
        ssp_rd_i = 1'b0;
        mb_rd_i = 1'b0;
        ssc_irq_n_i = 1'b1;
        ssp_irq_n_i = 1'b1;
        mb_irq_n_i = 1'b1;
        ssp_audio_i = '0;
        mb_audio_l_i = '0;
        mb_audio_r_i = '0;
        repeat (3) @(posedge clk_logic_w);
        #1;
        system_reset_n_w = 1'b1;

        // Data priority, direction and IRQ merge, checked every cycle
        repeat (200) begin
            next_cycle();
            {ssc_d_i, ssp_d_i, mb_d_i, bus_d_i} = $urandom;
            {ssc_rd_i, ssp_rd_i, mb_rd_i} = $urandom_range(0, 7);
            {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = $urandom_range(0, 7);
            a2_rw_n_i = $urandom_range(0, 1);
        end

        // Audio mix with the speaker at rest
        repeat (5) begin
            ssp_audio_i = $urandom_range(0, 1023);
            mb_audio_l_i = $urandom_range(0, 1023);
            mb_audio_r_i = $urandom_range(0, 1023);
            hold_and_check_audio();
        end

        access_address(`A2_SPEAKER_ADDR, 1'b1);
        access_address(16'hC031, 1'b0);
        access_address(16'hC020, 1'b0);
        access_address(`A2_SPEAKER_ADDR, 1'b1);

        check_heartbeat();
        check_indicators();

        $display("Error counts: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- rtl/a2_card_top.sv
`timescale 1ns/10ps
`include "a2_card_config.svh"

module a2_card_top
    import a2_card_pkg::*;
#(
    parameter int LED_PERIOD_CYCLES = `A2_LED_PERIOD_CYCLES
) (
    input  logic          clk_logic_w,
    input  logic          system_reset_n_w,
    input  logic          a2_phi1_i,
    input  logic          a2_q3_i,
    input  logic          a2_7m_i,
    input  bus_addr_t     a2_a_i,
    input  logic          a2_rw_n_i,
    input  bus_data_t     bus_d_i,
    input  bus_data_t     ssc_d_i,
    input  bus_data_t     ssp_d_i,
    input  bus_data_t     mb_d_i,
    input  logic          ssc_rd_i,
    input  logic          ssp_rd_i,
    input  logic          mb_rd_i,
    input  logic          ssc_irq_n_i,
    input  logic          ssp_irq_n_i,
    input  logic          mb_irq_n_i,
    input  source_audio_t ssp_audio_i,
    input  source_audio_t mb_audio_l_i,
    input  source_audio_t mb_audio_r_i,
    output bus_data_t     a2_d_o,
    output logic          a2_d_dir_o,
    output logic          a2_irq_n_o,
    output audio_sample_t audio_l_o,
    output audio_sample_t audio_r_o,
    output logic          led_o,
    output logic          phi1_ind_o,
    output logic          q3_ind_o
);

    logic phi1_rise_w;
    logic q3_rise_w;
    logic bus_drive_w;

    bus_clock_sync i_sync_phi1 (
        .clk_logic_w(clk_logic_w), .system_reset_n_w(system_reset_n_w),
        .clk_async_i(a2_phi1_i), .level_o(), .rise_o(phi1_rise_w), .fall_o()
    );

    bus_clock_sync i_sync_q3 (
        .clk_logic_w(clk_logic_w), .system_reset_n_w(system_reset_n_w),
        .clk_async_i(a2_q3_i), .level_o(), .rise_o(q3_rise_w), .fall_o()
    );

    // 7M has no user yet
    bus_clock_sync i_sync_7m (
        .clk_logic_w(clk_logic_w), .system_reset_n_w(system_reset_n_w),
        .clk_async_i(a2_7m_i), .level_o(), .rise_o(), .fall_o()
    );

    card_bus_arbiter i_card_bus_arbiter (
        .ssc_d_i(ssc_d_i), .ssp_d_i(ssp_d_i), .mb_d_i(mb_d_i), .bus_d_i(bus_d_i),
        .ssc_rd_i(ssc_rd_i), .ssp_rd_i(ssp_rd_i), .mb_rd_i(mb_rd_i),
        .ssc_irq_n_i(ssc_irq_n_i), .ssp_irq_n_i(ssp_irq_n_i), .mb_irq_n_i(mb_irq_n_i),
        .data_o(a2_d_o), .data_dir_o(a2_d_dir_o), .irq_n_o(a2_irq_n_o),
        .bus_drive_o(bus_drive_w)
    );

    card_audio i_card_audio (
        .clk_logic_w(clk_logic_w), .system_reset_n_w(system_reset_n_w),
        .phi1_rise_i(phi1_rise_w), .a2_a_i(a2_a_i), .a2_rw_n_i(a2_rw_n_i),
        .ssp_audio_i(ssp_audio_i), .mb_audio_l_i(mb_audio_l_i), .mb_audio_r_i(mb_audio_r_i),
        .audio_l_o(audio_l_o), .audio_r_o(audio_r_o)
    );

    status_led #(
        .PERIOD_CYCLES(LED_PERIOD_CYCLES)
    ) i_status_led (
        .clk_logic_w(clk_logic_w), .system_reset_n_w(system_reset_n_w),
        .bus_drive_i(bus_drive_w), .phi1_rise_i(phi1_rise_w), .q3_rise_i(q3_rise_w),
        .led_o(led_o), .phi1_ind_o(phi1_ind_o), .q3_ind_o(q3_ind_o)
    );

endmodule

//--- rtl/status_led.sv
`timescale 1ns/10ps
`include "a2_card_config.svh"

module status_led #(
    parameter int PERIOD_CYCLES = `A2_LED_PERIOD_CYCLES
) (
    input  logic clk_logic_w,
    input  logic system_reset_n_w,
    input  logic bus_drive_i,      // Some card is answering a read
    input  logic phi1_rise_i,
    input  logic q3_rise_i,
    output logic led_o,
    output logic phi1_ind_o,
    output logic q3_ind_o
);

    localparam int CNT_W = $clog2(PERIOD_CYCLES + 1);
    localparam int IND_BIT = `A2_INDICATOR_BIT;

    logic [CNT_W-1:0] period_cnt_r;
    logic             activity_r;   // Bus seen busy since the last wrap
    logic             wrap_w;
    logic [IND_BIT:0] phi1_cnt_r;
    logic [IND_BIT:0] q3_cnt_r;

    assign wrap_w = (period_cnt_r == CNT_W'(PERIOD_CYCLES - 1));

    // Heartbeat, held solid while the bus is in use
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            period_cnt_r <= '0;
            activity_r   <= 1'b0;
            led_o        <= 1'b0;
        end else if (wrap_w) begin
            period_cnt_r <= '0;
            activity_r   <= 1'b0;
            if (activity_r || bus_drive_i) begin
                led_o <= 1'b1;
            end else begin
                led_o <= ~led_o;
            end
        end else begin
            period_cnt_r <= period_cnt_r + 1'b1;
            activity_r   <= activity_r | bus_drive_i;
        end
    end

    // Slow indicators, one per bus clock
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            phi1_cnt_r <= '0;
            q3_cnt_r   <= '0;
        end else begin
            if (phi1_rise_i) phi1_cnt_r <= phi1_cnt_r + 1'b1;
            if (q3_rise_i)   q3_cnt_r   <= q3_cnt_r + 1'b1;
        end
    end

    assign phi1_ind_o = phi1_cnt_r[IND_BIT];
    assign q3_ind_o   = q3_cnt_r[IND_BIT];

    a_period_range: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        period_cnt_r < PERIOD_CYCLES
    ) else $error("status_led: period counter out of range");

endmodule

//--- rtl/card_audio.sv
`timescale 1ns/10ps
`include "a2_card_config.svh"

module card_audio
    import a2_card_pkg::*;
(
    input  logic          clk_logic_w,
    input  logic          system_reset_n_w,
    input  logic          phi1_rise_i,     // Synchronized Phi1 rising edge
    input  bus_addr_t     a2_a_i,
    input  logic          a2_rw_n_i,
    input  source_audio_t ssp_audio_i,
    input  source_audio_t mb_audio_l_i,
    input  source_audio_t mb_audio_r_i,
    output audio_sample_t audio_l_o,
    output audio_sample_t audio_r_o
);

    logic       speaker_r;
    logic       speaker_hit_w;
    mix_audio_t speaker_ext_w;
    mix_audio_t ssp_ext_w;
    mix_audio_t mb_l_ext_w;
    mix_audio_t mb_r_ext_w;
    logic [15:0] sum_l_w;
    logic [15:0] sum_r_w;

    // Any access to the soft switch, read or write, flips the cone
    assign speaker_hit_w = phi1_rise_i && (a2_a_i == `A2_SPEAKER_ADDR);

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            speaker_r <= 1'b0;
        end else if (speaker_hit_w) begin
            speaker_r <= ~speaker_r;
        end
    end

    // Bring every source into the 13-bit unsigned mix range
    assign speaker_ext_w = mix_audio_t'(speaker_r) << `A2_SPEAKER_SHIFT;
    assign ssp_ext_w     = mix_audio_t'(ssp_audio_i) << `A2_SOURCE_SHIFT;
    assign mb_l_ext_w    = mix_audio_t'(mb_audio_l_i) << `A2_SOURCE_SHIFT;
    assign mb_r_ext_w    = mix_audio_t'(mb_audio_r_i) << `A2_SOURCE_SHIFT;

    // Three 13-bit terms cannot reach the sign bit of 16
    assign sum_l_w = 16'(ssp_ext_w) + 16'(mb_l_ext_w) + 16'(speaker_ext_w);
    assign sum_r_w = 16'(ssp_ext_w) + 16'(mb_r_ext_w) + 16'(speaker_ext_w);

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= audio_sample_t'(sum_l_w);
            audio_r_o <= audio_sample_t'(sum_r_w);
        end
    end

    // Bus address and direction must be settled when Phi1 samples them
    a_bus_known: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        phi1_rise_i |-> !$isunknown({a2_a_i, a2_rw_n_i})
    ) else $error("card_audio: bus undefined at Phi1 sample point");

endmodule

//--- rtl/card_bus_arbiter.sv
`timescale 1ns/10ps
`include "a2_card_config.svh"

module card_bus_arbiter
    import a2_card_pkg::*;
(
    input  bus_data_t ssc_d_i,      // SuperSerial read data
    input  bus_data_t ssp_d_i,      // SuperSprite read data
    input  bus_data_t mb_d_i,       // Mockingboard read data
    input  bus_data_t bus_d_i,      // Latched bus data, echoed back when idle
    input  logic      ssc_rd_i,
    input  logic      ssp_rd_i,
    input  logic      mb_rd_i,
    input  logic      ssc_irq_n_i,
    input  logic      ssp_irq_n_i,
    input  logic      mb_irq_n_i,
    output bus_data_t data_o,
    output logic      data_dir_o,   // 1 drives the buffer toward the Apple II
    output logic      irq_n_o,
    output logic      bus_drive_o
);

    logic any_rd_w;

    assign any_rd_w = ssc_rd_i | ssp_rd_i | mb_rd_i;

    // Fixed priority, serial card first
    always_comb begin
        if (ssc_rd_i) begin
            data_o = ssc_d_i;
        end else if (ssp_rd_i) begin
            data_o = ssp_d_i;
        end else if (mb_rd_i) begin
            data_o = mb_d_i;
        end else begin
            data_o = bus_d_i;
        end
    end

    assign bus_drive_o = any_rd_w;
    assign data_dir_o  = any_rd_w & `A2_BUS_DATA_OUT_ENABLE;

    // Open-collector style merge of the active-low requests
    assign irq_n_o = `A2_IRQ_OUT_ENABLE ? (ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i) : 1'b1;

    // The bus buffer must face inward unless some card answers a read
    always_comb begin
        a_dir_needs_read: assert final (!data_dir_o || ssc_rd_i || ssp_rd_i || mb_rd_i)
            else $error("card_bus_arbiter: data bus driven with no read strobe");
    end

endmodule

//--- rtl/bus_clock_sync.sv
`timescale 1ns/10ps
`include "a2_card_config.svh"

module bus_clock_sync (
    input  logic clk_logic_w,
    input  logic system_reset_n_w,
    input  logic clk_async_i,       // Raw Apple II bus clock
    output logic level_o,
    output logic rise_o,
    output logic fall_o
);

    localparam int STAGES = `A2_SYNC_STAGES;

    logic [STAGES-1:0] sync_r;   // Bit 0 is the metastable stage
    logic              prev_r;   // Level one cycle back, for edge detection

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            sync_r <= '0;
            prev_r <= 1'b0;
        end else begin
            sync_r <= {sync_r[STAGES-2:0], clk_async_i};
            prev_r <= sync_r[STAGES-1];
        end
    end

    assign level_o = sync_r[STAGES-1];

    // Pulses line up with the change of level_o
    assign rise_o = level_o & ~prev_r;
    assign fall_o = ~level_o & prev_r;

    a_no_double_edge: assert property (
        @(posedge clk_logic_w) disable iff (!system_reset_n_w)
        !(rise_o && fall_o)
    ) else $error("bus_clock_sync: rise and fall in the same cycle");

endmodule

//--- rtl/a2_card_pkg.sv
package a2_card_pkg;

    // Apple II bus words
    typedef logic [7:0]  bus_data_t;
    typedef logic [15:0] bus_addr_t;

    // Unsigned sample as delivered by a slot card
    typedef logic [9:0] source_audio_t;

    // Source after shifting into the common mix range
    typedef logic [12:0] mix_audio_t;

    // Final stereo sample
    typedef logic signed [15:0] audio_sample_t;

endpackage

//--- rtl/a2_card_config.svh
`ifndef A2_CARD_CONFIG_SVH
`define A2_CARD_CONFIG_SVH

// Output enables toward the Apple II bus
`define A2_BUS_DATA_OUT_ENABLE 1'b1  // Card may drive the data bus
`define A2_IRQ_OUT_ENABLE      1'b1  // Card may pull IRQ low

// Speaker soft switch, reads and writes both toggle
`define A2_SPEAKER_ADDR 16'hC030

// Heartbeat half period in logic clock cycles
`define A2_LED_PERIOD_CYCLES 10_000_000

// Edge counter bit shown on the bus clock indicators
`define A2_INDICATOR_BIT 10

// Flops in each bus clock synchronizer
`define A2_SYNC_STAGES 2

// Placement of the audio sources inside the 13-bit mix term
`define A2_SPEAKER_SHIFT 12  // Speaker bit lands on bit 12
`define A2_SOURCE_SHIFT  3   // 10-bit card audio lands on bits 12:3

`endif
